// ==== source/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

  // register values, memory data and addresses
  typedef logic [31:0] word_t;

  // reorder buffer tag, zero is no instruction
  typedef logic [3:0] rob_id_t;

  // address offset, sign-extended onto the base
  typedef logic [11:0] imm_t;

  // byte enables of one word
  typedef logic [3:0] strb_t;

  // loads first, stores from SB upwards
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } ls_op_t;

  // head-of-queue memory sequencer
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_LOAD,
    MEM_STORE
  } mem_state_t;

  // default queue depth, any power of two from 2 up
  parameter int LSQ_DEPTH = 8;

endpackage

`default_nettype wire

// ==== source/lsq_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_queue #(
  parameter int LSQ_DEPTH = lsq_pkg::LSQ_DEPTH
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   issue_valid,
  output logic                  issue_ready,
  input  wire lsq_pkg::ls_op_t  issue_op,
  input  wire lsq_pkg::rob_id_t issue_dest,
  input  wire lsq_pkg::rob_id_t issue_qj,
  input  wire lsq_pkg::rob_id_t issue_qk,
  input  wire lsq_pkg::word_t   issue_vj,
  input  wire lsq_pkg::word_t   issue_vk,
  input  wire lsq_pkg::imm_t    issue_imm,
  input  wire lsq_pkg::rob_id_t cdb_dest,
  input  wire lsq_pkg::word_t   cdb_value,
  input  wire lsq_pkg::rob_id_t result_dest,
  input  wire lsq_pkg::word_t   result_value,
  input  wire lsq_pkg::rob_id_t commit_dest,
  input  wire                   flush,
  input  wire                   head_pop,
  output logic                  head_valid,
  output lsq_pkg::ls_op_t       head_op,
  output lsq_pkg::word_t        head_addr,
  output lsq_pkg::word_t        head_data,
  output lsq_pkg::rob_id_t      head_dest
);
  import lsq_pkg::*;

  localparam int PTR_W = $clog2(LSQ_DEPTH);
  localparam int EXT_W = $bits(word_t) - $bits(imm_t);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   cnt_t;

  // entry payload, vj turns into the address once computed
  ls_op_t  op_q   [LSQ_DEPTH];
  rob_id_t dest_q [LSQ_DEPTH];
  rob_id_t qj_q   [LSQ_DEPTH];
  rob_id_t qk_q   [LSQ_DEPTH];
  word_t   vj_q   [LSQ_DEPTH];
  word_t   vk_q   [LSQ_DEPTH];
  imm_t    imm_q  [LSQ_DEPTH];

  logic [LSQ_DEPTH-1:0] busy;
  logic [LSQ_DEPTH-1:0] committed;
  logic [LSQ_DEPTH-1:0] addr_done;
  ptr_t head;
  ptr_t tail;
  cnt_t count;

  logic alloc;
  logic calc_found;
  ptr_t calc_idx;
  cnt_t kept;
  logic head_store;

  function automatic logic tag_hit(rob_id_t tag, rob_id_t bus);
    return (bus != '0) && (tag == bus);
  endfunction

  assign issue_ready = (count != cnt_t'(LSQ_DEPTH));
  assign alloc       = issue_valid && issue_ready && !flush;

  // head entry towards the sequencer
  assign head_op    = op_q[head];
  assign head_addr  = vj_q[head];
  assign head_data  = vk_q[head];
  assign head_dest  = dest_q[head];
  assign head_store = (op_q[head] >= SB);
  assign head_valid = busy[head] && addr_done[head] && (qk_q[head] == '0) &&
                      (!head_store || committed[head]);

  // lowest index with a ready base wins the adder
  always_comb begin
    calc_found = 1'b0;
    calc_idx   = '0;
    for (int i = LSQ_DEPTH - 1; i >= 0; i--) begin
      if (busy[i] && (qj_q[i] == '0) && !addr_done[i]) begin
        calc_found = 1'b1;
        calc_idx   = ptr_t'(i);
      end
    end
  end

  // length of the committed run starting at the head
  always_comb begin : trim_scan
    ptr_t idx;
    logic run;
    kept = '0;
    run  = 1'b1;
    for (int k = 0; k < LSQ_DEPTH; k++) begin
      idx = head + ptr_t'(k);
      if (run && (k < count) && committed[idx]) begin
        kept = cnt_t'(k + 1);
      end else begin
        run = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= '0;
      committed <= '0;
      addr_done <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (calc_found) begin
        addr_done[calc_idx] <= 1'b1;
      end
      if (commit_dest != '0) begin
        for (int i = 0; i < LSQ_DEPTH; i++) begin
          if (busy[i] && (dest_q[i] == commit_dest)) begin
            committed[i] <= 1'b1;
          end
        end
      end
      if (head_pop) begin
        busy[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      if (flush) begin
        // drop everything past the committed run
        for (int i = 0; i < LSQ_DEPTH; i++) begin
          if (cnt_t'(ptr_t'(ptr_t'(i) - head)) >= kept) begin
            busy[i] <= 1'b0;
          end
        end
        tail  <= head + ptr_t'(kept);
        count <= kept - cnt_t'(head_pop);
      end else begin
        if (alloc) begin
          busy[tail]      <= 1'b1;
          committed[tail] <= 1'b0;
          addr_done[tail] <= 1'b0;
          tail            <= tail + 1'b1;
        end
        count <= count + cnt_t'(alloc) - cnt_t'(head_pop);
      end
    end
  end

  always_ff @(posedge clk) begin
    // wakeup from both broadcasts
    for (int i = 0; i < LSQ_DEPTH; i++) begin
      if (tag_hit(qj_q[i], cdb_dest)) begin
        qj_q[i] <= '0;
        vj_q[i] <= cdb_value;
      end else if (tag_hit(qj_q[i], result_dest)) begin
        qj_q[i] <= '0;
        vj_q[i] <= result_value;
      end
      if (tag_hit(qk_q[i], cdb_dest)) begin
        qk_q[i] <= '0;
        vk_q[i] <= cdb_value;
      end else if (tag_hit(qk_q[i], result_dest)) begin
        qk_q[i] <= '0;
        vk_q[i] <= result_value;
      end
    end

    if (calc_found) begin
      vj_q[calc_idx] <= vj_q[calc_idx] + {{EXT_W{imm_q[calc_idx][11]}}, imm_q[calc_idx]};
    end

    if (alloc) begin
      op_q[tail]   <= issue_op;
      dest_q[tail] <= issue_dest;
      imm_q[tail]  <= issue_imm;
      // same-cycle capture at issue
      if (tag_hit(issue_qj, cdb_dest)) begin
        qj_q[tail] <= '0;
        vj_q[tail] <= cdb_value;
      end else if (tag_hit(issue_qj, result_dest)) begin
        qj_q[tail] <= '0;
        vj_q[tail] <= result_value;
      end else begin
        qj_q[tail] <= issue_qj;
        vj_q[tail] <= issue_vj;
      end
      if (tag_hit(issue_qk, cdb_dest)) begin
        qk_q[tail] <= '0;
        vk_q[tail] <= cdb_value;
      end else if (tag_hit(issue_qk, result_dest)) begin
        qk_q[tail] <= '0;
        vk_q[tail] <= result_value;
      end else begin
        qk_q[tail] <= issue_qk;
        vk_q[tail] <= issue_vk;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lsq_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_mem_ctrl (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   flush,
  input  wire                   head_valid,
  input  wire lsq_pkg::ls_op_t  head_op,
  input  wire lsq_pkg::word_t   head_addr,
  input  wire lsq_pkg::word_t   head_data,
  input  wire lsq_pkg::rob_id_t head_dest,
  output logic                  head_pop,
  output logic                  mem_valid,
  output logic                  mem_write,
  output lsq_pkg::word_t        mem_addr,
  output lsq_pkg::word_t        mem_wdata,
  output lsq_pkg::strb_t        mem_wstrb,
  input  wire                   mem_ready,
  input  wire lsq_pkg::word_t   mem_rdata,
  output logic                  load_done,
  output lsq_pkg::ls_op_t       load_op,
  output logic [1:0]            load_byte_sel,
  output lsq_pkg::word_t        load_word,
  output lsq_pkg::rob_id_t      load_dest
);
  import lsq_pkg::*;

  mem_state_t state;
  logic       flushed;
  logic       head_store;
  strb_t      next_strb;
  word_t      next_wdata;

  assign head_store = (head_op >= SB);

  // store data replicated so every lane carries it
  always_comb begin
    case (head_op)
      SB: begin
        next_strb  = strb_t'(4'b0001 << head_addr[1:0]);
        next_wdata = {4{head_data[7:0]}};
      end
      SH: begin
        next_strb  = strb_t'(4'b0011 << head_addr[1:0]);
        next_wdata = {2{head_data[15:0]}};
      end
      SW: begin
        next_strb  = 4'b1111;
        next_wdata = head_data;
      end
      default: begin
        next_strb  = '0;
        next_wdata = head_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= MEM_IDLE;
      flushed <= 1'b0;
    end else begin
      case (state)
        MEM_IDLE: begin
          if (head_valid && !flush) begin
            state   <= head_store ? MEM_STORE : MEM_LOAD;
            flushed <= 1'b0;
          end
        end
        MEM_LOAD: begin
          // the entry is gone, still finish the handshake
          if (flush) begin
            flushed <= 1'b1;
          end
          if (mem_ready) begin
            state <= MEM_IDLE;
          end
        end
        MEM_STORE: begin
          if (mem_ready) begin
            state <= MEM_IDLE;
          end
        end
        default: state <= MEM_IDLE;
      endcase
    end
  end

  // request fields latched at launch, held until mem_ready
  always_ff @(posedge clk) begin
    if (state == MEM_IDLE) begin
      mem_write     <= head_store;
      mem_addr      <= {head_addr[31:2], 2'b00};
      mem_wdata     <= next_wdata;
      mem_wstrb     <= next_strb;
      load_op       <= head_op;
      load_byte_sel <= head_addr[1:0];
      load_dest     <= head_dest;
    end
  end

  assign mem_valid = (state != MEM_IDLE);
  assign load_done = (state == MEM_LOAD) && mem_ready && !flushed && !flush;
  assign head_pop  = load_done || ((state == MEM_STORE) && mem_ready);
  assign load_word = mem_rdata;

endmodule

`default_nettype wire

// ==== source/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   flush,
  input  wire                   load_done,
  input  wire lsq_pkg::ls_op_t  load_op,
  input  wire [1:0]             load_byte_sel,
  input  wire lsq_pkg::word_t   load_word,
  input  wire lsq_pkg::rob_id_t load_dest,
  output lsq_pkg::rob_id_t      result_dest,
  output lsq_pkg::word_t        result_value
);
  import lsq_pkg::*;

  logic [7:0]  byte_val;
  logic [15:0] half_val;
  word_t       ext_val;

  // lane select, halves use the upper select bit only
  assign byte_val = load_word[{load_byte_sel, 3'b000} +: 8];
  assign half_val = load_word[{load_byte_sel[1], 4'b0000} +: 16];

  always_comb begin
    case (load_op)
      LB:      ext_val = {{24{byte_val[7]}}, byte_val};
      LBU:     ext_val = {24'b0, byte_val};
      LH:      ext_val = {{16{half_val[15]}}, half_val};
      LHU:     ext_val = {16'b0, half_val};
      default: ext_val = load_word;
    endcase
  end

  // one-cycle result bus
  always_ff @(posedge clk) begin
    if (rst) begin
      result_dest <= '0;
    end else if (load_done && !flush) begin
      result_dest <= load_dest;
    end else begin
      result_dest <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_done) begin
      result_value <= ext_val;
    end
  end

endmodule

`default_nettype wire

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit #(
  parameter int LSQ_DEPTH = lsq_pkg::LSQ_DEPTH
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   issue_valid,
  output logic                  issue_ready,
  input  wire lsq_pkg::ls_op_t  issue_op,
  input  wire lsq_pkg::rob_id_t issue_dest,
  input  wire lsq_pkg::rob_id_t issue_qj,
  input  wire lsq_pkg::rob_id_t issue_qk,
  input  wire lsq_pkg::word_t   issue_vj,
  input  wire lsq_pkg::word_t   issue_vk,
  input  wire lsq_pkg::imm_t    issue_imm,
  input  wire lsq_pkg::rob_id_t cdb_dest,
  input  wire lsq_pkg::word_t   cdb_value,
  input  wire lsq_pkg::rob_id_t commit_dest,
  input  wire                   flush,
  output logic                  mem_valid,
  output logic                  mem_write,
  output lsq_pkg::word_t        mem_addr,
  output lsq_pkg::word_t        mem_wdata,
  output lsq_pkg::strb_t        mem_wstrb,
  input  wire                   mem_ready,
  input  wire lsq_pkg::word_t   mem_rdata,
  output lsq_pkg::rob_id_t      result_dest,
  output lsq_pkg::word_t        result_value
);
  import lsq_pkg::*;

  // queue head towards the sequencer
  logic    head_valid;
  ls_op_t  head_op;
  word_t   head_addr;
  word_t   head_data;
  rob_id_t head_dest;
  logic    head_pop;

  // completed load towards the aligner
  logic       load_done;
  ls_op_t     load_op;
  logic [1:0] load_byte_sel;
  word_t      load_word;
  rob_id_t    load_dest;

  lsq_queue #(
    .LSQ_DEPTH(LSQ_DEPTH)
  ) u_queue (
    .clk(clk),
    .rst(rst),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_op(issue_op),
    .issue_dest(issue_dest),
    .issue_qj(issue_qj),
    .issue_qk(issue_qk),
    .issue_vj(issue_vj),
    .issue_vk(issue_vk),
    .issue_imm(issue_imm),
    .cdb_dest(cdb_dest),
    .cdb_value(cdb_value),
    .result_dest(result_dest),
    .result_value(result_value),
    .commit_dest(commit_dest),
    .flush(flush),
    .head_pop(head_pop),
    .head_valid(head_valid),
    .head_op(head_op),
    .head_addr(head_addr),
    .head_data(head_data),
    .head_dest(head_dest)
  );

  lsq_mem_ctrl u_mem_ctrl (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .head_valid(head_valid),
    .head_op(head_op),
    .head_addr(head_addr),
    .head_data(head_data),
    .head_dest(head_dest),
    .head_pop(head_pop),
    .mem_valid(mem_valid),
    .mem_write(mem_write),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .load_done(load_done),
    .load_op(load_op),
    .load_byte_sel(load_byte_sel),
    .load_word(load_word),
    .load_dest(load_dest)
  );

  load_align u_align (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .load_done(load_done),
    .load_op(load_op),
    .load_byte_sel(load_byte_sel),
    .load_word(load_word),
    .load_dest(load_dest),
    .result_dest(result_dest),
    .result_value(result_value)
  );

endmodule

`default_nettype wire

// ==== tb/lsu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_assertions (
  input wire                   clk,
  input wire                   rst,
  input wire                   issue_valid,
  input wire                   issue_ready,
  input wire lsq_pkg::rob_id_t issue_dest,
  input wire lsq_pkg::rob_id_t commit_dest,
  input wire                   flush,
  input wire                   head_valid,
  input wire lsq_pkg::rob_id_t head_dest,
  input wire                   head_pop,
  input wire                   mem_valid,
  input wire                   mem_write,
  input wire lsq_pkg::word_t   mem_addr,
  input wire lsq_pkg::word_t   mem_wdata,
  input wire lsq_pkg::strb_t   mem_wstrb,
  input wire                   mem_ready,
  input wire lsq_pkg::rob_id_t result_dest
);

  int fail_count = 0;

  // one bit per reorder-buffer tag, set once its commit was seen
  logic [15:0] commit_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_seen <= '0;
    end else begin
      if (issue_valid && issue_ready && !flush) begin
        commit_seen[issue_dest] <= 1'b0;
      end
      if (commit_dest != '0) begin
        commit_seen[commit_dest] <= 1'b1;
      end
    end
  end

  a_reset_state: assert property (@(posedge clk)
    rst |=> !mem_valid && (result_dest == '0) && issue_ready && !head_pop)
    else begin
      $error("outputs not idle after reset");
      fail_count++;
    end

  // request fields hold while the memory stalls
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write) &&
                                $stable(mem_wdata) && $stable(mem_wstrb))
    else begin
      $error("memory request changed or dropped while mem_ready was low");
      fail_count++;
    end

  a_store_committed: assert property (@(posedge clk) disable iff (rst)
    mem_valid && mem_write |-> commit_seen[head_dest])
    else begin
      $error("store reached the memory port before its commit");
      fail_count++;
    end

  a_launch: assert property (@(posedge clk) disable iff (rst)
    head_valid && !mem_valid && !flush |=> mem_valid)
    else begin
      $error("ready head entry was not launched on the next cycle");
      fail_count++;
    end

  a_result_pulse: assert property (@(posedge clk) disable iff (rst)
    (result_dest != '0) |=> (result_dest == '0))
    else begin
      $error("result bus stayed busy for more than one cycle");
      fail_count++;
    end

  a_result_source: assert property (@(posedge clk) disable iff (rst)
    (result_dest != '0) |-> $past(mem_valid && mem_ready && !mem_write))
    else begin
      $error("result appeared without a completed load");
      fail_count++;
    end

  // a flush cancels whatever would follow
  a_flush_result: assert property (@(posedge clk) disable iff (rst)
    flush |=> (result_dest == '0))
    else begin
      $error("result appeared right after a flush");
      fail_count++;
    end

endmodule

bind load_store_unit lsu_assertions u_assertions (
  .clk(clk),
  .rst(rst),
  .issue_valid(issue_valid),
  .issue_ready(issue_ready),
  .issue_dest(issue_dest),
  .commit_dest(commit_dest),
  .flush(flush),
  .head_valid(head_valid),
  .head_dest(head_dest),
  .head_pop(head_pop),
  .mem_valid(mem_valid),
  .mem_write(mem_write),
  .mem_addr(mem_addr),
  .mem_wdata(mem_wdata),
  .mem_wstrb(mem_wstrb),
  .mem_ready(mem_ready),
  .result_dest(result_dest)
);

`default_nettype wire

// ==== tb/tb_load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit;
  import lsq_pkg::*;

  localparam int DEPTH = LSQ_DEPTH;
  // some 55 memory transactions of under 10 cycles each need far fewer cycles
  localparam int MAX_CYCLES = 3000;

  logic    clk;
  logic    rst;
  logic    issue_valid;
  logic    issue_ready;
  ls_op_t  issue_op;
  rob_id_t issue_dest;
  rob_id_t issue_qj;
  rob_id_t issue_qk;
  word_t   issue_vj;
  word_t   issue_vk;
  imm_t    issue_imm;
  rob_id_t cdb_dest;
  word_t   cdb_value;
  rob_id_t commit_dest;
  logic    flush;
  logic    mem_valid;
  logic    mem_write;
  word_t   mem_addr;
  word_t   mem_wdata;
  strb_t   mem_wstrb;
  logic    mem_ready = 1'b0;
  word_t   mem_rdata = '0;
  rob_id_t result_dest;
  word_t   result_value;

  word_t mem [256];
  word_t ref_mem [256];

  // expected loads in issue order and expected stores in commit order
  rob_id_t    exp_dest [$];
  word_t      exp_value [$];
  logic [7:0] exp_st_idx [$];
  strb_t      exp_st_strb [$];
  word_t      exp_st_data [$];

  int      errors = 0;
  int      cycles = 0;
  rob_id_t next_tag = 4'd1;

  // request as seen by the memory model
  logic       req_active = 1'b0;
  int         req_wait;
  logic       req_write;
  logic [7:0] req_idx;
  word_t      req_wdata;
  strb_t      req_wstrb;
  // a negative fixed_wait keeps the latency random
  int         fixed_wait = -1;

  load_store_unit #(
    .LSQ_DEPTH(DEPTH)
  ) uut (
    .clk(clk),
    .rst(rst),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_op(issue_op),
    .issue_dest(issue_dest),
    .issue_qj(issue_qj),
    .issue_qk(issue_qk),
    .issue_vj(issue_vj),
    .issue_vk(issue_vk),
    .issue_imm(issue_imm),
    .cdb_dest(cdb_dest),
    .cdb_value(cdb_value),
    .commit_dest(commit_dest),
    .flush(flush),
    .mem_valid(mem_valid),
    .mem_write(mem_write),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .result_dest(result_dest),
    .result_value(result_value)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  function automatic word_t fill_word(int i);
    return {8'(i), 8'(i ^ 8'h3c), 8'(~i), 8'(i * 5 + 1)};
  endfunction

  function automatic word_t byte_mask(strb_t s);
    word_t m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{s[i]}};
    end
    return m;
  endfunction

  function automatic strb_t lane_mask(ls_op_t op, word_t addr);
    case (op)
      SB:      return {addr[1:0] == 2'd3, addr[1:0] == 2'd2, addr[1:0] == 2'd1,
                       addr[1:0] == 2'd0};
      SH:      return addr[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic word_t lane_data(ls_op_t op, word_t addr, word_t data);
    word_t d;
    d = '0;
    case (op)
      SB:      d[8*addr[1:0] +: 8] = data[7:0];
      SH:      d[16*addr[1] +: 16] = data[15:0];
      default: d = data;
    endcase
    return d;
  endfunction

  function automatic word_t expect_load(ls_op_t op, word_t addr);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = ref_mem[addr[9:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'b0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'b0, h};
      default: return w;
    endcase
  endfunction

  function automatic word_t rand_addr(ls_op_t op);
    word_t a;
    a = {22'b0, 8'($urandom_range(0, 255)), 2'($urandom_range(0, 3))};
    if (op == LH || op == LHU || op == SH) begin
      a[0] = 1'b0;
    end
    if (op == LW || op == SW) begin
      a[1:0] = 2'b00;
    end
    return a;
  endfunction

  // tags 13 to 15 are kept free for broadcasts
  function automatic rob_id_t take_tag();
    rob_id_t t;
    t = next_tag;
    next_tag = (next_tag == 4'd12) ? 4'd1 : next_tag + 4'd1;
    return t;
  endfunction

  task automatic issue_entry(input ls_op_t op, input rob_id_t dest, input word_t addr,
                             input rob_id_t qj, input word_t data, input logic keep,
                             input logic cdb_same, output word_t base);
    imm_t  imm;
    word_t m;
    imm  = imm_t'($urandom);
    base = addr - {{20{imm[11]}}, imm};
    issue_valid = 1'b1;
    issue_op    = op;
    issue_dest  = dest;
    issue_qj    = qj;
    issue_vj    = (qj != '0) ? 32'hdead_beef : base;
    issue_qk    = '0;
    issue_vk    = data;
    issue_imm   = imm;
    if (cdb_same) begin
      cdb_dest  = qj;
      cdb_value = base;
    end
    if (keep && op >= SB) begin
      m = byte_mask(lane_mask(op, addr));
      ref_mem[addr[9:2]] = (ref_mem[addr[9:2]] & ~m) | (lane_data(op, addr, data) & m);
      exp_st_idx.push_back(addr[9:2]);
      exp_st_strb.push_back(lane_mask(op, addr));
      exp_st_data.push_back(lane_data(op, addr, data));
    end else if (keep) begin
      exp_dest.push_back(dest);
      exp_value.push_back(expect_load(op, addr));
    end
    while (!issue_ready) @(negedge clk);
    @(negedge clk);
    issue_valid = 1'b0;
    cdb_dest    = '0;
  endtask

  task automatic commit_tag(input rob_id_t tag);
    commit_dest = tag;
    @(negedge clk);
    commit_dest = '0;
  endtask

  task automatic wait_drain();
    while (exp_dest.size() != 0 || exp_st_idx.size() != 0 || mem_valid) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  // memory with 0 to 3 cycles of latency unless fixed_wait is set
  always @(negedge clk) begin
    if (rst) begin
      mem_ready  = 1'b0;
      req_active = 1'b0;
    end else if (mem_ready) begin
      mem_ready  = 1'b0;
      req_active = 1'b0;
      if (req_write) begin
        if (exp_st_idx.size() == 0) begin
          errors++;
          $display("unexpected store to word address 0x%08h reached memory", {req_idx, 2'b00});
        end else begin
          if (req_idx != exp_st_idx[0]) begin
            errors++;
            $display("** Error mem_addr: expected 0x%08h, got 0x%08h",
                     {22'b0, exp_st_idx[0], 2'b00}, {22'b0, req_idx, 2'b00});
          end
          if (req_wstrb != exp_st_strb[0]) begin
            errors++;
            $display("** Error mem_wstrb: expected 0x%01h, got 0x%01h",
                     exp_st_strb[0], req_wstrb);
          end
          if ((req_wdata & byte_mask(req_wstrb)) != exp_st_data[0]) begin
            errors++;
            $display("** Error mem_wdata: expected 0x%08h, got 0x%08h", exp_st_data[0],
                     req_wdata & byte_mask(req_wstrb));
          end
          void'(exp_st_idx.pop_front());
          void'(exp_st_strb.pop_front());
          void'(exp_st_data.pop_front());
        end
        mem[req_idx] = (mem[req_idx] & ~byte_mask(req_wstrb)) |
                       (req_wdata & byte_mask(req_wstrb));
      end
    end else if (mem_valid) begin
      if (!req_active) begin
        req_active = 1'b1;
        req_wait   = (fixed_wait >= 0) ? fixed_wait : $urandom_range(0, 3);
        req_write  = mem_write;
        req_idx    = mem_addr[9:2];
        req_wdata  = mem_wdata;
        req_wstrb  = mem_wstrb;
      end
      if (req_wait == 0) begin
        mem_ready = 1'b1;
        mem_rdata = mem[req_idx];
      end else begin
        req_wait--;
      end
    end
  end

  // results sampled between edges
  always @(negedge clk) begin
    if (!rst && result_dest != '0) begin
      if (exp_dest.size() == 0) begin
        errors++;
        $display("result for tag %0d arrived with no load outstanding", result_dest);
      end else begin
        if (result_dest != exp_dest[0]) begin
          errors++;
          $display("** Error result_dest: expected 0x%01h, got 0x%01h",
                   exp_dest[0], result_dest);
        end
        if (result_value != exp_value[0]) begin
          errors++;
          $display("** Error result_value: expected 0x%08h, got 0x%08h",
                   exp_value[0], result_value);
        end
        void'(exp_dest.pop_front());
        void'(exp_value.pop_front());
      end
    end
  end

  initial begin
    ls_op_t  op;
    word_t   addr;
    word_t   base;
    rob_id_t tag;
    rob_id_t tags [DEPTH];
    void'($urandom(92208));
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_op    = LW;
    issue_dest  = '0;
    issue_qj    = '0;
    issue_qk    = '0;
    issue_vj    = '0;
    issue_vk    = '0;
    issue_imm   = '0;
    cdb_dest    = '0;
    cdb_value   = '0;
    commit_dest = '0;
    flush       = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // loads of every size with ready bases
    for (int i = 0; i < 24; i++) begin
      op = ls_op_t'($urandom_range(0, 4));
      issue_entry(op, take_tag(), rand_addr(op), '0, '0, 1'b1, 1'b0, base);
    end
    wait_drain();

    // committed stores, each read back as a word
    for (int i = 0; i < 8; i++) begin
      op   = ls_op_t'($urandom_range(5, 7));
      addr = rand_addr(op);
      tag  = take_tag();
      issue_entry(op, tag, addr, '0, $urandom, 1'b1, 1'b0, base);
      commit_tag(tag);
      issue_entry(LW, take_tag(), {addr[31:2], 2'b00}, '0, '0, 1'b1, 1'b0, base);
    end
    wait_drain();

    // base arrives later on the broadcast
    op = ls_op_t'($urandom_range(0, 4));
    issue_entry(op, take_tag(), rand_addr(op), 4'd13, '0, 1'b1, 1'b0, base);
    op = ls_op_t'($urandom_range(0, 4));
    addr = base;
    issue_entry(op, take_tag(), rand_addr(op), '0, '0, 1'b1, 1'b0, base);
    repeat (3) @(negedge clk);
    cdb_dest  = 4'd13;
    cdb_value = addr;
    @(negedge clk);
    cdb_dest = '0;
    wait_drain();
    // base captured in the issue cycle
    op = ls_op_t'($urandom_range(0, 4));
    issue_entry(op, take_tag(), rand_addr(op), 4'd14, '0, 1'b1, 1'b1, base);
    wait_drain();

    // fill the queue with uncommitted stores
    for (int i = 0; i < DEPTH; i++) begin
      op      = ls_op_t'($urandom_range(5, 7));
      tags[i] = take_tag();
      issue_entry(op, tags[i], rand_addr(op), '0, $urandom, 1'b1, 1'b0, base);
    end
    if (issue_ready !== 1'b0) begin
      errors++;
      $display("** Error issue_ready: expected 0x0, got 0x%01h", issue_ready);
    end
    for (int i = 0; i < DEPTH; i++) begin
      commit_tag(tags[i]);
    end
    wait_drain();

    // flush keeps only the committed store at the head
    tag = take_tag();
    issue_entry(SW, tag, rand_addr(SW), '0, $urandom, 1'b1, 1'b0, base);
    issue_entry(SB, take_tag(), rand_addr(SB), '0, $urandom, 1'b0, 1'b0, base);
    issue_entry(LW, take_tag(), rand_addr(LW), '0, '0, 1'b0, 1'b0, base);
    issue_entry(SH, take_tag(), rand_addr(SH), '0, $urandom, 1'b0, 1'b0, base);
    commit_tag(tag);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_drain();

    // flush while a load waits on memory
    fixed_wait = 2;
    issue_entry(LW, take_tag(), rand_addr(LW), '0, '0, 1'b0, 1'b0, base);
    while (!mem_valid) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_drain();

    // flush in the cycle the load completes
    fixed_wait = 0;
    issue_entry(LW, take_tag(), rand_addr(LW), '0, '0, 1'b0, 1'b0, base);
    while (!mem_valid) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_drain();
    fixed_wait = -1;

    $display("errors: data %0d, assertions %0d", errors, uut.u_assertions.fail_count);
    if (errors == 0 && uut.u_assertions.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/lsq_pkg.sv
source/lsq_queue.sv
source/lsq_mem_ctrl.sv
source/load_align.sv
source/load_store_unit.sv
tb/lsu_assertions.sv
tb/tb_load_store_unit.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

obj_dir/Vtb_load_store_unit: all.f source/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_load_store_unit

test: obj_dir/Vtb_load_store_unit
	./obj_dir/Vtb_load_store_unit +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
